/* Bender.yml */
package:
  name: move_gen

sources:
  - files:
      - hw/chess_pkg.sv
      - hw/slider_moves.sv
      - hw/leaper_moves.sv
      - hw/move_store.sv
      - hw/move_gen_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_move_gen.sv

/* flist.f */
+incdir+test
hw/chess_pkg.sv
hw/slider_moves.sv
hw/leaper_moves.sv
hw/move_store.sv
hw/move_gen_top.sv
test/tb_move_gen.sv

/* hw/chess_pkg.sv */
package chess_pkg;

   localparam int PIECE_BITS    = 4;
   localparam int BOARD_SQUARES = 64;
   localparam int BOARD_BITS    = BOARD_SQUARES * PIECE_BITS;

   // row * 8 + col, row 0 on white's side
   typedef logic [5:0] square_t;

   typedef enum logic [2:0]
   {
      kind_none   = 3'd0,
      kind_pawn   = 3'd1,
      kind_knight = 3'd2,
      kind_bishop = 3'd3,
      kind_rook   = 3'd4,
      kind_queen  = 3'd5,
      kind_king   = 3'd6
   } piece_kind_t;

   // one square, read raw or as color and kind
   typedef union packed
   {
      logic [PIECE_BITS-1:0] code;
      struct packed
      {
         logic        black;   // set for black pieces
         piece_kind_t kind;
      } f;
   } piece_t;

   localparam logic [PIECE_BITS-1:0] PIECE_EMPTY = 4'd0;

endpackage

/* hw/leaper_moves.sv */
`timescale 1ns/1ps

module leaper_moves
(
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             start,
   input  logic                             clear_moves,
   input  logic                             white_to_move,
   input  logic [chess_pkg::BOARD_BITS-1:0] board,
   output logic                             leaper_move,
   output logic                             done,
   output chess_pkg::square_t               from,
   output chess_pkg::square_t               to,
   output chess_pkg::piece_t                captured
);

   import chess_pkg::*;

   localparam logic [1:0] S_IDLE   = 2'd0;
   localparam logic [1:0] S_SQUARE = 2'd1;
   localparam logic [1:0] S_STEP   = 2'd2;
   localparam logic [1:0] S_DONE   = 2'd3;

   logic [1:0]        state;
   square_t           sq;
   piece_t            cur;
   piece_t            piece;
   logic              own_leaper;
   logic [2:0]        off_idx;
   logic signed [4:0] off_row;
   logic signed [4:0] off_col;
   logic signed [4:0] dst_row;
   logic signed [4:0] dst_col;
   square_t           dst_sq;
   piece_t            target;
   logic              on_board;

   assign cur        = board[sq * PIECE_BITS +: PIECE_BITS];
   assign own_leaper = cur.code != PIECE_EMPTY && cur.f.black == !white_to_move &&
                       (cur.f.kind == kind_knight || cur.f.kind == kind_king);
   assign dst_row    = $signed({2'b00, sq[5:3]}) + off_row;
   assign dst_col    = $signed({2'b00, sq[2:0]}) + off_col;
   assign dst_sq     = {dst_row[2:0], dst_col[2:0]};
   assign target     = board[dst_sq * PIECE_BITS +: PIECE_BITS];
   assign on_board   = dst_row[4:3] == 2'b00 && dst_col[4:3] == 2'b00;
   assign done       = state == S_DONE;

   // knight jumps first, king ring second
   always_comb
   begin
      case ({piece.f.kind == kind_king, off_idx})
         4'h0:    {off_row, off_col} = {-5'sd2, -5'sd1};
         4'h1:    {off_row, off_col} = {-5'sd1, -5'sd2};
         4'h2:    {off_row, off_col} = {5'sd1, -5'sd2};
         4'h3:    {off_row, off_col} = {5'sd2, -5'sd1};
         4'h4:    {off_row, off_col} = {5'sd2, 5'sd1};
         4'h5:    {off_row, off_col} = {5'sd1, 5'sd2};
         4'h6:    {off_row, off_col} = {-5'sd1, 5'sd2};
         4'h7:    {off_row, off_col} = {-5'sd2, 5'sd1};
         4'h8:    {off_row, off_col} = {-5'sd1, -5'sd1};
         4'h9:    {off_row, off_col} = {-5'sd1, 5'sd0};
         4'ha:    {off_row, off_col} = {-5'sd1, 5'sd1};
         4'hb:    {off_row, off_col} = {5'sd0, -5'sd1};
         4'hc:    {off_row, off_col} = {5'sd0, 5'sd1};
         4'hd:    {off_row, off_col} = {5'sd1, -5'sd1};
         4'he:    {off_row, off_col} = {5'sd1, 5'sd0};
         default: {off_row, off_col} = {5'sd1, 5'sd1};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= S_IDLE;
         leaper_move <= 1'b0;
      end
      else
      begin
         leaper_move <= 1'b0;
         case (state)
            S_IDLE:
               if (start)
               begin
                  sq    <= '0;
                  state <= S_SQUARE;
               end
            S_SQUARE:
               if (own_leaper)
               begin
                  piece   <= cur;
                  off_idx <= 3'd0;
                  state   <= S_STEP;
               end
               else if (sq == 6'd63)
                  state <= S_DONE;
               else
                  sq <= sq + 6'd1;
            S_STEP:
            begin
               if (on_board && (target.code == PIECE_EMPTY || target.f.black == white_to_move))
               begin
                  leaper_move <= 1'b1;
                  from        <= sq;
                  to          <= dst_sq;
                  captured    <= target;
               end
               off_idx <= off_idx + 3'd1;
               if (off_idx == 3'd7)   // all eight offsets tried
               begin
                  if (sq == 6'd63)
                     state <= S_DONE;
                  else
                  begin
                     sq    <= sq + 6'd1;
                     state <= S_SQUARE;
                  end
               end
            end
            S_DONE:
               if (clear_moves)
                  state <= S_IDLE;
            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

/* hw/move_gen_top.sv */
`timescale 1ns/1ps

module move_gen_top #(
   parameter int  MAX_MOVES  = 256,
   localparam int INDEX_BITS = $clog2(MAX_MOVES),
   localparam int COUNT_BITS = $clog2(MAX_MOVES + 1)
)
(
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             board_valid,
   input  logic [chess_pkg::BOARD_BITS-1:0] board_in,
   input  logic                             white_to_move_in,
   input  logic [INDEX_BITS-1:0]            move_index,
   input  logic                             clear_moves,
   output logic                             moves_ready,
   output logic [COUNT_BITS-1:0]            move_count,
   output chess_pkg::square_t               move_from,
   output chess_pkg::square_t               move_to,
   output chess_pkg::piece_t                move_captured
);

   import chess_pkg::*;

   logic                  idle;
   logic                  start;
   logic                  clear_go;
   logic [BOARD_BITS-1:0] board_q;
   logic                  white_q;
   logic                  slider_move;
   logic                  slider_done;
   square_t               slider_from;
   square_t               slider_to;
   piece_t                slider_captured;
   logic                  leaper_move;
   logic                  leaper_done;
   square_t               leaper_from;
   square_t               leaper_to;
   piece_t                leaper_captured;

   assign start    = board_valid && idle;    // stray strobes dropped
   assign clear_go = clear_moves && moves_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
         idle <= 1'b1;
      else if (start)
         idle <= 1'b0;
      else if (clear_go)
         idle <= 1'b1;
   end

   // both scanners walk this copy
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         board_q <= board_in;
         white_q <= white_to_move_in;
      end
   end

   slider_moves slider0
   (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .clear_moves   (clear_go),
      .white_to_move (white_q),
      .board         (board_q),
      .slider_move   (slider_move),
      .done          (slider_done),
      .from          (slider_from),
      .to            (slider_to),
      .captured      (slider_captured)
   );

   leaper_moves leaper0
   (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .clear_moves   (clear_go),
      .white_to_move (white_q),
      .board         (board_q),
      .leaper_move   (leaper_move),
      .done          (leaper_done),
      .from          (leaper_from),
      .to            (leaper_to),
      .captured      (leaper_captured)
   );

   move_store #(
      .MAX_MOVES (MAX_MOVES)
   ) store0
   (
      .clk             (clk),
      .reset           (reset),
      .start           (start),
      .clear_moves     (clear_go),
      .slider_move     (slider_move),
      .slider_from     (slider_from),
      .slider_to       (slider_to),
      .slider_captured (slider_captured),
      .slider_done     (slider_done),
      .leaper_move     (leaper_move),
      .leaper_from     (leaper_from),
      .leaper_to       (leaper_to),
      .leaper_captured (leaper_captured),
      .leaper_done     (leaper_done),
      .move_index      (move_index),
      .moves_ready     (moves_ready),
      .move_count      (move_count),
      .move_from       (move_from),
      .move_to         (move_to),
      .move_captured   (move_captured)
   );

endmodule

/* hw/move_store.sv */
`timescale 1ns/1ps

module move_store #(
   parameter int  MAX_MOVES  = 256,
   localparam int INDEX_BITS = $clog2(MAX_MOVES),
   localparam int COUNT_BITS = $clog2(MAX_MOVES + 1)
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,
   input  logic                  clear_moves,
   input  logic                  slider_move,
   input  chess_pkg::square_t    slider_from,
   input  chess_pkg::square_t    slider_to,
   input  chess_pkg::piece_t     slider_captured,
   input  logic                  slider_done,
   input  logic                  leaper_move,
   input  chess_pkg::square_t    leaper_from,
   input  chess_pkg::square_t    leaper_to,
   input  chess_pkg::piece_t     leaper_captured,
   input  logic                  leaper_done,
   input  logic [INDEX_BITS-1:0] move_index,
   output logic                  moves_ready,
   output logic [COUNT_BITS-1:0] move_count,
   output chess_pkg::square_t    move_from,
   output chess_pkg::square_t    move_to,
   output chess_pkg::piece_t     move_captured
);

   import chess_pkg::*;

   // from, to, captured
   localparam int REC_BITS = 2 * $bits(square_t) + PIECE_BITS;

   logic [REC_BITS-1:0]   mem [MAX_MOVES];
   logic [REC_BITS-1:0]   rd_rec;
   logic [COUNT_BITS-1:0] count;
   logic [COUNT_BITS:0]   leaper_addr;
   logic                  slider_ok;
   logic                  leaper_ok;

   // leaper lands behind the slider when both arrive together
   assign leaper_addr = slider_move ? {1'b0, count} + 1'b1 : {1'b0, count};
   assign slider_ok   = slider_move && count < MAX_MOVES;
   assign leaper_ok   = leaper_move && leaper_addr < MAX_MOVES;

   always_ff @(posedge clk)
   begin
      if (slider_ok)
         mem[count[INDEX_BITS-1:0]] <= {slider_from, slider_to, slider_captured};
      if (leaper_ok)
         mem[leaper_addr[INDEX_BITS-1:0]] <= {leaper_from, leaper_to, leaper_captured};
      rd_rec <= mem[move_index];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (start)
         count <= '0;
      else
         count <= count + COUNT_BITS'(slider_ok) + COUNT_BITS'(leaper_ok);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         moves_ready <= 1'b0;
      else if (clear_moves)
         moves_ready <= 1'b0;
      else if (slider_done && leaper_done)
         moves_ready <= 1'b1;   // count is final by now
   end

   assign move_count = count;
   assign {move_from, move_to, move_captured} = rd_rec;

endmodule

/* hw/slider_moves.sv */
`timescale 1ns/1ps

module slider_moves
(
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             start,
   input  logic                             clear_moves,
   input  logic                             white_to_move,
   input  logic [chess_pkg::BOARD_BITS-1:0] board,
   output logic                             slider_move,
   output logic                             done,
   output chess_pkg::square_t               from,
   output chess_pkg::square_t               to,
   output chess_pkg::piece_t                captured
);

   import chess_pkg::*;

   localparam logic [2:0] S_IDLE   = 3'd0;
   localparam logic [2:0] S_SQUARE = 3'd1;
   localparam logic [2:0] S_DIR    = 3'd2;
   localparam logic [2:0] S_RAY    = 3'd3;
   localparam logic [2:0] S_DONE   = 3'd4;

   logic [2:0]        state;
   square_t           sq;
   piece_t            cur;
   piece_t            piece;
   logic              own_slider;
   logic [2:0]        dir_idx;
   logic [2:0]        dir_last;
   logic signed [4:0] step_row;
   logic signed [4:0] step_col;
   logic signed [4:0] ray_row;
   logic signed [4:0] ray_col;
   square_t           ray_sq;
   piece_t            target;
   logic              on_board;

   assign cur        = board[sq * PIECE_BITS +: PIECE_BITS];
   assign own_slider = cur.code != PIECE_EMPTY && cur.f.black == !white_to_move &&
                       (cur.f.kind == kind_queen || cur.f.kind == kind_rook ||
                        cur.f.kind == kind_bishop);
   assign dir_last   = (piece.f.kind == kind_rook) ? 3'd3 : 3'd7;
   assign ray_sq     = {ray_row[2:0], ray_col[2:0]};
   assign target     = board[ray_sq * PIECE_BITS +: PIECE_BITS];
   assign on_board   = ray_row[4:3] == 2'b00 && ray_col[4:3] == 2'b00;
   assign done       = state == S_DONE;

   // 0-3 orthogonal, 4-7 diagonal
   always_comb
   begin
      case (dir_idx)
         3'd0:    {step_row, step_col} = {5'sd0, 5'sd1};
         3'd1:    {step_row, step_col} = {5'sd0, -5'sd1};
         3'd2:    {step_row, step_col} = {5'sd1, 5'sd0};
         3'd3:    {step_row, step_col} = {-5'sd1, 5'sd0};
         3'd4:    {step_row, step_col} = {5'sd1, 5'sd1};
         3'd5:    {step_row, step_col} = {5'sd1, -5'sd1};
         3'd6:    {step_row, step_col} = {-5'sd1, 5'sd1};
         default: {step_row, step_col} = {-5'sd1, -5'sd1};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= S_IDLE;
         slider_move <= 1'b0;
      end
      else
      begin
         slider_move <= 1'b0;
         case (state)
            S_IDLE:
               if (start)
               begin
                  sq    <= '0;
                  state <= S_SQUARE;
               end
            S_SQUARE:
               if (own_slider)
               begin
                  piece   <= cur;
                  dir_idx <= (cur.f.kind == kind_bishop) ? 3'd4 : 3'd0;
                  state   <= S_DIR;
               end
               else if (sq == 6'd63)
                  state <= S_DONE;
               else
                  sq <= sq + 6'd1;
            S_DIR:
            begin
               ray_row <= $signed({2'b00, sq[5:3]}) + step_row;
               ray_col <= $signed({2'b00, sq[2:0]}) + step_col;
               state   <= S_RAY;
            end
            S_RAY:
            begin
               if (on_board && (target.code == PIECE_EMPTY || target.f.black == white_to_move))
               begin
                  slider_move <= 1'b1;
                  from        <= sq;
                  to          <= ray_sq;
                  captured    <= target;
               end
               if (on_board && target.code == PIECE_EMPTY)
               begin
                  ray_row <= ray_row + step_row;   // keep sliding
                  ray_col <= ray_col + step_col;
               end
               else if (dir_idx != dir_last)
               begin
                  dir_idx <= dir_idx + 3'd1;
                  state   <= S_DIR;
               end
               else if (sq == 6'd63)
                  state <= S_DONE;
               else
               begin
                  sq    <= sq + 6'd1;
                  state <= S_SQUARE;
               end
            end
            S_DONE:
               if (clear_moves)
                  state <= S_IDLE;
            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

/* test/tb_positions.svh */
`ifndef TB_POSITIONS_SVH
`define TB_POSITIONS_SVH

// columns: side to move (1 = white), expected moves, expected captures, board
// board groups run row 7 down to row 0, h-file digit first in each group
task automatic load_positions();
   // lone king in the corner
   add_position(1'b1, 3, 0,
      256'h00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000006);
   // knight on d4
   add_position(1'b1, 8, 0,
      256'h00000000_00000000_00000000_00000000_00002000_00000000_00000000_00000000);
   // rook on d4
   add_position(1'b1, 14, 0,
      256'h00000000_00000000_00000000_00000000_00004000_00000000_00000000_00000000);
   // queen on d4
   add_position(1'b1, 27, 0,
      256'h00000000_00000000_00000000_00000000_00005000_00000000_00000000_00000000);
   // black king on h8
   add_position(1'b0, 3, 0,
      256'hE0000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000);
   add_position(1'b1, 7, 0,
      256'h00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000300);
   // rook blocked by own king, takes the knight on a4
   add_position(1'b1, 11, 1,
      256'h00000000_00000000_00000000_00000000_0000000A_00000000_00000000_00060004);
   // black queen and king, both capture
   add_position(1'b0, 18, 2,
      256'h000ED000_00200900_00000000_00000000_00000000_00000000_00000000_00004000);
   // opening position, only knights move
   add_position(1'b1, 4, 0,
      256'hCABEDBAC_99999999_00000000_00000000_00000000_00000000_11111111_42365324);
   // queen and knight active together
   add_position(1'b1, 22, 3,
      256'hB0000005_00000000_00000000_00000000_00000000_09000000_00000000_2000000C);
   // king facing three pawns
   add_position(1'b1, 7, 3,
      256'h00000000_00000000_00000000_00099900_00006000_00000100_00000000_00000000);
   add_position(1'b0, 7, 1,
      256'hCA000000_00000000_00000000_00000000_10000000_00000000_00000000_00000000);
endtask

`endif

/* test/tb_move_gen.sv */
`timescale 1ns/1ps

module tb_move_gen;

   import chess_pkg::*;

   localparam int MAX_MOVES     = 256;
   localparam int INDEX_BITS    = $clog2(MAX_MOVES);
   localparam int COUNT_BITS    = $clog2(MAX_MOVES + 1);
   localparam int READY_TIMEOUT = 4000;
   localparam int STRAY_WINDOW  = 40;
   // white queen a1 and black queen h8 for the ignored strobe
   localparam logic [BOARD_BITS-1:0] STRAY_BOARD =
      256'hD0000000_00000000_00000000_00000000_00000000_00000000_00000000_00000005;

   logic                  clk;
   logic                  reset;
   logic                  board_valid;
   logic [BOARD_BITS-1:0] board_in;
   logic                  white_to_move_in;
   logic [INDEX_BITS-1:0] move_index;
   logic                  clear_moves;
   logic                  moves_ready;
   logic [COUNT_BITS-1:0] move_count;
   square_t               move_from;
   square_t               move_to;
   piece_t                move_captured;

   logic [BOARD_BITS-1:0] pos_board [$];
   logic                  pos_white [$];
   int                    pos_moves [$];
   int                    pos_caps [$];
   int                    value_errors;
   int                    timeouts;
   bit                    aborted;
   int                    row;

   move_gen_top #(
      .MAX_MOVES (MAX_MOVES)
   ) dut0
   (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .move_index       (move_index),
      .clear_moves      (clear_moves),
      .moves_ready      (moves_ready),
      .move_count       (move_count),
      .move_from        (move_from),
      .move_to          (move_to),
      .move_captured    (move_captured)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic add_position(input logic white, input int moves, input int caps,
                               input logic [BOARD_BITS-1:0] board);
      pos_board.push_back(board);
      pos_white.push_back(white);
      pos_moves.push_back(moves);
      pos_caps.push_back(caps);
   endtask

   `include "tb_positions.svh"

   function automatic bit movable_kind(input logic [2:0] kind);
      case (kind)
         kind_knight, kind_bishop, kind_rook, kind_queen, kind_king: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic wait_ready(input int stray_at, output bit ready);
      int cycles;
      ready  = 1'b0;
      cycles = 0;
      while (!ready && cycles < READY_TIMEOUT)
      begin
         @(posedge clk);
         board_valid <= (cycles == stray_at);   // stray start mid scan
         @(negedge clk);
         ready  = moves_ready;
         cycles = cycles + 1;
      end
   endtask

   task automatic read_moves(input int idx);
      int              i;
      int              caps;
      int              count;
      logic [3:0]      mover;
      logic [3:0]      victim;
      logic [BOARD_BITS-1:0] board;
      logic            side;
      bit              seen [0:4095];
      board = pos_board[idx];
      side  = pos_white[idx];
      caps  = 0;
      count = move_count;
      for (i = 0; i < 4096; i++)
         seen[i] = 1'b0;
      for (i = 0; i < count; i++)
      begin
         @(posedge clk);
         move_index <= INDEX_BITS'(i);
         @(posedge clk);
         @(negedge clk);   // registered read settled
         mover  = board[int'(move_from) * 4 +: 4];
         victim = board[int'(move_to) * 4 +: 4];
         // mover color must match the side to move
         if (mover == PIECE_EMPTY || mover[3] == side || !movable_kind(mover[2:0]))
         begin
            $display("** Error move_from: square %h holds %h, not a mover of this side",
                     move_from, mover);
            value_errors++;
         end
         if (move_captured !== victim)
         begin
            $display("** Error move_captured: got %h expected %h", move_captured, victim);
            value_errors++;
         end
         if (victim != PIECE_EMPTY && victim[3] != side)
         begin
            $display("** Error move_to: square %h holds own piece %h", move_to, victim);
            value_errors++;
         end
         if (seen[{move_from, move_to}])
         begin
            $display("** Error move_from/move_to: pair %h -> %h read twice", move_from,
                     move_to);
            value_errors++;
         end
         seen[{move_from, move_to}] = 1'b1;
         if (move_captured != PIECE_EMPTY)
            caps++;
      end
      if (caps != pos_caps[idx])
      begin
         $display("** Error move_captured: %h captures, expected %h", caps, pos_caps[idx]);
         value_errors++;
      end
   endtask

   task automatic clear_results();
      @(posedge clk);
      clear_moves <= 1'b1;
      @(posedge clk);
      clear_moves <= 1'b0;
      @(negedge clk);
      if (moves_ready !== 1'b0)
      begin
         $display("** Error moves_ready: got %h expected %h", moves_ready, 1'b0);
         value_errors++;
      end
   endtask

   task automatic run_position(input int idx);
      int stray_at;
      bit ready;
      stray_at = 1 + ($urandom % STRAY_WINDOW);
      @(posedge clk);
      board_in         <= pos_board[idx];
      white_to_move_in <= pos_white[idx];
      board_valid      <= 1'b1;
      @(posedge clk);
      board_valid      <= 1'b0;
      board_in         <= STRAY_BOARD;   // would change the count if taken
      white_to_move_in <= !pos_white[idx];
      wait_ready(stray_at, ready);
      if (!ready)
      begin
         $display("timeout: moves_ready never rose for position %0d", idx);
         timeouts++;
         aborted = 1'b1;
      end
      else
      begin
         if (move_count !== COUNT_BITS'(pos_moves[idx]))
         begin
            $display("** Error move_count: got %h expected %h (position %0d)", move_count,
                     COUNT_BITS'(pos_moves[idx]), idx);
            value_errors++;
         end
         @(posedge clk);
         board_valid <= 1'b0;
         read_moves(idx);
         clear_results();
      end
   endtask

   initial
   begin
      value_errors     = 0;
      timeouts         = 0;
      aborted          = 1'b0;
      reset            = 1'b1;
      board_valid      = 1'b0;
      board_in         = '0;
      white_to_move_in = 1'b0;
      move_index       = '0;
      clear_moves      = 1'b0;
      void'($urandom(32'h3726_5e24));
      load_positions();
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      if (moves_ready !== 1'b0)
      begin
         $display("** Error moves_ready: got %h expected %h", moves_ready, 1'b0);
         value_errors++;
      end
      if (move_count !== '0)
      begin
         $display("** Error move_count: got %h expected %h", move_count, 0);
         value_errors++;
      end
      for (row = 0; row < pos_board.size() && !aborted; row++)
         run_position(row);
      $display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
      if (value_errors == 0 && timeouts == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule
